//--- compile.f
hdl/i2c_pkg.sv
hdl/pong_link_pkg.sv
hdl/ball_frame_sequencer.sv
hdl/i2c_byte_master.sv
hdl/pong_link_tx.sv
tb/i2c_slave_monitor.sv
tb/tb_pong_link_tx.sv

//--- Bender.yml
package:
  name: pong_link_tx

sources:
  - files:
      - hdl/i2c_pkg.sv
      - hdl/pong_link_pkg.sv
      - hdl/ball_frame_sequencer.sv
      - hdl/i2c_byte_master.sv
      - hdl/pong_link_tx.sv
  - target: test
    files:
      - tb/i2c_slave_monitor.sv
      - tb/tb_pong_link_tx.sv

//--- tb/tb_pong_link_tx.sv
`default_nettype none

module tb_pong_link_tx
    import pong_link_pkg::*;
();

    localparam logic [7:0] DEV_ADDR   = 8'hAA;
    localparam int         CLK_DIV    = 2;
    localparam int         CLK_PERIOD = 40;
    localparam int         NUM_FRAMES = 40;
    // start, seven bytes and stop, plus handshake cycles
    localparam int FRAME_CYCLES  = (4 + 7 * 36 + 4) * CLK_DIV + 40;
    localparam int WATCHDOG_TIME = 2 * NUM_FRAMES * (FRAME_CYCLES + 16) * CLK_PERIOD;

    logic            clk;
    logic            reset;
    logic            ball_send;
    logic            lose_send;
    logic            abort;
    ball_state_t     ball;
    logic            scl_drive_low;
    logic            sda_drive_low;
    logic            busy;
    logic            frame_done;
    logic            nack_error;
    logic            ack_pull;
    logic            scl_bus;
    logic            sda_bus;
    int              nack_at;
    int              mon_frame_count;
    int              mon_frame_len;
    logic [7:0][7:0] mon_frame_bytes;

    int         seed;
    int         errors;
    int         accepted;
    int         done_count;
    int         nack_count;
    logic [7:0] exp_bytes [0:7];
    int         exp_len;
    int         exp_nack;
    logic       abort_seen;
    int         abort_len;  // bytes already on the bus when abort was first seen

    // wired-AND bus
    assign scl_bus = ~scl_drive_low;
    assign sda_bus = ~(sda_drive_low | ack_pull);

    pong_link_tx #(
        .DEV_ADDR(DEV_ADDR),
        .CLK_DIV (CLK_DIV)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .ball_send     (ball_send),
        .ball          (ball),
        .lose_send     (lose_send),
        .abort         (abort),
        .sda_in        (sda_bus),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low),
        .busy          (busy),
        .frame_done    (frame_done),
        .nack_error    (nack_error)
    );

    i2c_slave_monitor i_monitor (
        .scl         (scl_bus),
        .sda         (sda_bus),
        .nack_at     (nack_at),
        .ack_pull    (ack_pull),
        .frame_count (mon_frame_count),
        .frame_len   (mon_frame_len),
        .frame_bytes (mon_frame_bytes)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic ball_state_t random_ball();
        logic [31:0] r;
        r = $random(seed);
        return r[20:0];
    endfunction

    // expected bytes of the frame just accepted
    task automatic expect_frame();
        exp_bytes[0] = DEV_ADDR;
        if (lose_send) begin
            exp_bytes[1] = REG_LOSE;
            exp_bytes[2] = 8'h01;
            exp_len      = 3;
        end else begin
            exp_bytes[1] = REG_BALL;
            exp_bytes[2] = {ball.y[9:8], 6'b000000};
            exp_bytes[3] = ball.y[7:0];
            exp_bytes[4] = ball.vy;
            exp_bytes[5] = {6'b000000, ball.gravity};
            exp_bytes[6] = {7'b0000000, ball.collision};
            exp_len      = 7;
        end
        exp_nack   = nack_at;
        abort_seen = 1'b0;
    endtask

    task automatic check_frame();
        int   limit;
        int   got;
        logic nack_hit;
        done_count++;
        got   = mon_frame_len;
        limit = exp_len;
        if (exp_nack >= 0 && exp_nack < exp_len) begin
            limit = exp_nack + 1;  // stop right after the refused byte
        end
        nack_hit = (exp_nack >= 0) && (got > exp_nack);
        check_value($sformatf("frame %0d stops", done_count), done_count, mon_frame_count);
        check_value($sformatf("frame %0d busy", done_count), 0, busy);
        if (!abort_seen) begin
            check_value($sformatf("frame %0d length", done_count), limit, got);
        end else begin
            if (abort_len + 1 < limit) begin
                limit = abort_len + 1;  // only the byte in flight may finish
            end
            if (got > limit) begin
                $display("Aborted frame %0d carried %0d bytes, more than %0d",
                         done_count, got, limit);
                errors++;
            end
        end
        check_value($sformatf("frame %0d nack_error", done_count), nack_hit, nack_error);
        for (int i = 0; i < got && i < exp_len; i++) begin
            check_value($sformatf("frame %0d byte %0d", done_count, i),
                        exp_bytes[i], mon_frame_bytes[i]);
        end
        if (nack_error) begin
            nack_count++;
        end
    endtask

    // reference model, sees the same pre-edge values as the DUT
    always @(posedge clk) begin
        if (!reset) begin
            if (frame_done) begin
                check_frame();
            end else if (nack_error) begin
                $display("nack_error pulsed without frame_done");
                errors++;
            end
            if ((ball_send || lose_send) && !busy) begin
                accepted++;
                expect_frame();
            end
            if (abort && busy && !abort_seen) begin
                abort_seen = 1'b1;
                abort_len  = mon_frame_len;
            end
        end
    end

    task automatic run_frame(input int abort_delay);
        int          cycles;
        logic [31:0] r;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            r = $random(seed);
            if (cycles == abort_delay) begin
                abort <= 1'b1;
            end
            // stray strobe early on, busy is surely high then
            if (cycles >= 2 && cycles <= 10 && r[5:0] == 6'd0) begin
                ball      <= random_ball();
                ball_send <= r[6];
                lose_send <= ~r[6];
            end else begin
                ball_send <= 1'b0;
                lose_send <= 1'b0;
            end
        end while (!frame_done);
        abort <= 1'b0;
    endtask

    initial begin
        int          n;
        int          kind;
        int          abort_delay;
        logic [31:0] r;
        seed       = 50;
        errors     = 0;
        accepted   = 0;
        done_count = 0;
        nack_count = 0;
        reset      = 1'b1;
        ball_send  = 1'b0;
        lose_send  = 1'b0;
        abort      = 1'b0;
        ball       = '0;
        nack_at    = -1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("idle scl", 1, scl_bus);
            check_value("idle sda", 1, sda_bus);
            check_value("idle busy", 0, busy);
        end
        for (n = 0; n < NUM_FRAMES; n++) begin
            r = $random(seed);
            repeat (r[2:0]) @(posedge clk);
            kind = r[6:4];  // 0 lose, 1 both together, else ball
            abort_delay = (r[9:8] == 2'd1) ? int'(r[20:12]) + 1 : -1;
            @(posedge clk);
            r = $random(seed);
            ball      <= random_ball();
            ball_send <= (kind != 0);
            lose_send <= (kind <= 1);
            nack_at   <= (r[2:0] == 3'd0) ? int'(r[10:8]) : -1;
            @(posedge clk);
            ball_send <= 1'b0;
            lose_send <= 1'b0;
            run_frame(abort_delay);
        end
        repeat (8) @(posedge clk);
        check_value("accepted strobes vs frame_done", accepted, done_count);
        check_value("accepted strobes vs bus frames", accepted, mon_frame_count);
        $display("errors: %0d  accepted: %0d  frames: %0d  nacks: %0d",
                 errors, accepted, done_count, nack_count);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout after %0d time units with %0d frames done", WATCHDOG_TIME, done_count);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/i2c_slave_monitor.sv
`default_nettype none

module i2c_slave_monitor (
    input  logic            scl,
    input  logic            sda,
    input  int              nack_at,  // byte position left without ack, -1 for none
    output logic            ack_pull,
    output int              frame_count,
    output int              frame_len,  // bytes finished in the current frame
    output logic [7:0][7:0] frame_bytes
);

    logic       in_frame;
    logic [7:0] shift;
    int         bit_pos;  // 8 and up is the ack slot
    int         byte_pos;

    initial begin
        ack_pull    = 1'b0;
        in_frame    = 1'b0;
        shift       = 8'h00;
        bit_pos     = 0;
        byte_pos    = 0;
        frame_count = 0;
        frame_len   = 0;
        frame_bytes = '0;
    end

    // start, sda falls while scl is high
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            in_frame    = 1'b1;
            bit_pos     = 0;
            byte_pos    = 0;
            frame_len   = 0;
            frame_bytes = '0;
        end
    end

    // stop, sda rises while scl is high
    always @(posedge sda) begin
        if (scl === 1'b1 && in_frame) begin
            in_frame    = 1'b0;
            frame_count = frame_count + 1;
        end
    end

    always @(posedge scl) begin
        if (in_frame) begin
            if (bit_pos < 8) begin
                shift   = {shift[6:0], sda};
                bit_pos = bit_pos + 1;
                if (bit_pos == 8 && byte_pos < 8) begin
                    frame_bytes[byte_pos] = shift;
                end
            end else if (bit_pos == 9) begin
                bit_pos = 10;  // ack clocked
            end
        end
    end

    always @(negedge scl) begin
        if (in_frame) begin
            if (bit_pos == 8) begin
                ack_pull = (byte_pos != nack_at);
                bit_pos  = 9;
            end else if (bit_pos == 10) begin
                ack_pull  = 1'b0;
                byte_pos  = byte_pos + 1;
                frame_len = byte_pos;
                bit_pos   = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/pong_link_tx.sv
`default_nettype none

module pong_link_tx
    import i2c_pkg::*;
    import pong_link_pkg::*;
#(
    parameter logic [7:0] DEV_ADDR = 8'hAA,
    parameter int         CLK_DIV  = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        ball_send,
    input  ball_state_t ball,
    input  logic        lose_send,
    input  logic        abort,
    input  logic        sda_in,
    output logic        scl_drive_low,
    output logic        sda_drive_low,
    output logic        busy,
    output logic        frame_done,
    output logic        nack_error
);

    i2c_cmd_t cmd;
    logic     cmd_valid;
    logic     ready;
    logic     ack_ok;

    ball_frame_sequencer #(
        .DEV_ADDR(DEV_ADDR)
    ) i_sequencer (
        .clk        (clk),
        .reset      (reset),
        .ball_send  (ball_send),
        .ball       (ball),
        .lose_send  (lose_send),
        .abort      (abort),
        .ready      (ready),
        .ack_ok     (ack_ok),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .busy       (busy),
        .frame_done (frame_done),
        .nack_error (nack_error)
    );

    i2c_byte_master #(
        .CLK_DIV(CLK_DIV)
    ) i_master (
        .clk           (clk),
        .reset         (reset),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .sda_in        (sda_in),
        .ready         (ready),
        .ack_ok        (ack_ok),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low)
    );

endmodule

`default_nettype wire

//--- hdl/i2c_byte_master.sv
`default_nettype none

module i2c_byte_master
    import i2c_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  i2c_cmd_t cmd,
    input  logic     cmd_valid,
    input  logic     sda_in,
    output logic     ready,
    output logic     ack_ok,
    output logic     scl_drive_low,
    output logic     sda_drive_low
);

    localparam int DIV_W = $clog2(CLK_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       quarter;
    logic [3:0]       bit_cnt;
    logic [7:0]       shift;
    i2c_op_t          op_q;
    logic             tick;
    logic             last_quarter;
    logic             ack_bit;
    logic             op_done;
    logic             next_sda_bit;

    // returns {scl_low, sda_low} for one quarter of a command
    function automatic logic [1:0] line_drive(
        input i2c_op_t    op,
        input logic [1:0] q,
        input logic       sda_bit
    );
        logic scl_low;
        logic sda_low;
        scl_low = 1'b0;
        sda_low = 1'b0;
        case (op)
            I2C_START: begin
                scl_low = (q == 2'd3);
                sda_low = (q != 2'd0);  // falls while scl is high
            end
            I2C_WRITE: begin
                scl_low = (q == 2'd0) || (q == 2'd3);
                sda_low = ~sda_bit;
            end
            default: begin
                scl_low = (q == 2'd0);
                sda_low = (q <= 2'd1);  // rises while scl is high
            end
        endcase
        return {scl_low, sda_low};
    endfunction

    assign tick         = !ready && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_quarter = (quarter == 2'(I2C_QUARTERS - 1));
    assign ack_bit      = (bit_cnt == 4'(I2C_BITS_PER_BYTE));
    assign op_done      = last_quarter && ((op_q != I2C_WRITE) || ack_bit);

    // sda level wanted in the quarter that follows this one
    always_comb begin
        if (last_quarter) begin
            next_sda_bit = (bit_cnt == 4'(I2C_BITS_PER_BYTE - 1)) ? 1'b1 : shift[6];
        end else begin
            next_sda_bit = ack_bit ? 1'b1 : shift[7];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready         <= 1'b1;
            ack_ok        <= 1'b0;
            scl_drive_low <= 1'b0;
            sda_drive_low <= 1'b0;
            div_cnt       <= '0;
            quarter       <= 2'd0;
            bit_cnt       <= 4'd0;
            op_q          <= I2C_STOP;
        end else if (ready) begin
            if (cmd_valid) begin
                ready   <= 1'b0;
                op_q    <= cmd.op;
                div_cnt <= '0;
                quarter <= 2'd0;
                bit_cnt <= 4'd0;
                {scl_drive_low, sda_drive_low} <= line_drive(cmd.op, 2'd0, cmd.data[7]);
            end
        end else if (tick) begin
            div_cnt <= '0;
            quarter <= quarter + 2'd1;
            // ack sampled at the middle of the high phase
            if (op_q == I2C_WRITE && ack_bit && quarter == 2'd1) begin
                ack_ok <= ~sda_in;
            end
            if (op_done) begin
                ready <= 1'b1;  // lines keep their last level
            end else begin
                if (last_quarter) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
                {scl_drive_low, sda_drive_low} <= line_drive(op_q, quarter + 2'd1, next_sda_bit);
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // data shifter, msb goes out first
    always_ff @(posedge clk) begin
        if (ready && cmd_valid) begin
            shift <= cmd.data;
        end else if (tick && last_quarter && !op_done) begin
            shift <= {shift[6:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- hdl/ball_frame_sequencer.sv
`default_nettype none

module ball_frame_sequencer
    import i2c_pkg::*;
    import pong_link_pkg::*;
#(
    parameter logic [7:0] DEV_ADDR = 8'hAA
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        ball_send,
    input  ball_state_t ball,
    input  logic        lose_send,
    input  logic        abort,
    input  logic        ready,
    input  logic        ack_ok,
    output i2c_cmd_t    cmd,
    output logic        cmd_valid,
    output logic        busy,
    output logic        frame_done,
    output logic        nack_error
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT
    } seq_state_t;

    // position inside the frame
    typedef enum logic [2:0] {
        STEP_START,
        STEP_DEV,
        STEP_REG,
        STEP_DATA,
        STEP_STOP
    } step_t;

    seq_state_t  state;
    step_t       step;
    byte_cnt_t   byte_idx;
    byte_cnt_t   data_len;
    logic        nack_seen;
    logic        accept;
    logic        wrote_byte;
    logic        last_byte;
    logic [7:0]  reg_addr;
    frame_data_t data_buf;

    // strobes only count while idle
    assign accept = (state == SEQ_IDLE) && (ball_send || lose_send);

    assign wrote_byte = (step == STEP_DEV) || (step == STEP_REG) || (step == STEP_DATA);
    assign last_byte  = (byte_idx == data_len - 1'b1);

    assign cmd_valid = (state == SEQ_ISSUE) && ready;

    always_comb begin
        cmd.op   = I2C_WRITE;
        cmd.data = 8'h00;
        case (step)
            STEP_START: cmd.op = I2C_START;
            STEP_DEV:   cmd.data = DEV_ADDR;
            STEP_REG:   cmd.data = reg_addr;
            STEP_DATA:  cmd.data = data_buf[byte_idx];
            default:    cmd.op = I2C_STOP;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= SEQ_IDLE;
            step       <= STEP_START;
            byte_idx   <= '0;
            data_len   <= '0;
            nack_seen  <= 1'b0;
            busy       <= 1'b0;
            frame_done <= 1'b0;
            nack_error <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            nack_error <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        state     <= SEQ_ISSUE;
                        step      <= STEP_START;
                        byte_idx  <= '0;
                        nack_seen <= 1'b0;
                        busy      <= 1'b1;
                        // lose wins over a simultaneous ball strobe
                        data_len  <= lose_send ? byte_cnt_t'(1) : byte_cnt_t'(BALL_DATA_BYTES);
                    end
                end
                SEQ_ISSUE: begin
                    if (ready) begin
                        state <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (ready) begin
                        state <= SEQ_ISSUE;
                        if (step == STEP_STOP) begin
                            state      <= SEQ_IDLE;
                            busy       <= 1'b0;
                            frame_done <= 1'b1;
                            nack_error <= nack_seen;
                        end else if (wrote_byte && !ack_ok) begin
                            step      <= STEP_STOP;  // no ack, give up
                            nack_seen <= 1'b1;
                        end else if (abort) begin
                            step <= STEP_STOP;
                        end else begin
                            case (step)
                                STEP_START: step <= STEP_DEV;
                                STEP_DEV:   step <= STEP_REG;
                                STEP_REG:   step <= STEP_DATA;
                                default: begin
                                    if (last_byte) begin
                                        step <= STEP_STOP;
                                    end else begin
                                        byte_idx <= byte_idx + 1'b1;
                                    end
                                end
                            endcase
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // frame payload, loaded once per accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            if (lose_send) begin
                data_buf <= frame_data_t'(LOSE_DATA);
                reg_addr <= REG_LOSE;
            end else begin
                data_buf <= pack_ball(ball);
                reg_addr <= REG_BALL;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/pong_link_pkg.sv
`default_nettype none

package pong_link_pkg;

    typedef struct packed {
        logic [9:0]        y;
        logic signed [7:0] vy;
        logic [1:0]        gravity;
        logic              collision;
    } ball_state_t;

    // register map on the far board
    localparam logic [7:0] REG_BALL = 8'h00;
    localparam logic [7:0] REG_LOSE = 8'h04;

    localparam int BALL_DATA_BYTES = 5;
    localparam logic [7:0] LOSE_DATA = 8'h01;

    typedef logic [$clog2(BALL_DATA_BYTES + 1)-1:0] byte_cnt_t;
    typedef logic [BALL_DATA_BYTES-1:0][7:0] frame_data_t;

    function automatic frame_data_t pack_ball(input ball_state_t b);
        frame_data_t d;
        d[0] = {b.y[9:8], 6'b0};
        d[1] = b.y[7:0];
        d[2] = b.vy;
        d[3] = {6'b0, b.gravity};
        d[4] = {7'b0, b.collision};
        return d;
    endfunction

endpackage

`default_nettype wire

//--- hdl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // byte-level commands understood by the master
    typedef enum logic [1:0] {
        I2C_START = 2'd0,
        I2C_WRITE = 2'd1,
        I2C_STOP  = 2'd2
    } i2c_op_t;

    typedef struct packed {
        i2c_op_t    op;
        logic [7:0] data;  // only used by write
    } i2c_cmd_t;

    // data bits per byte, the ack slot follows
    localparam int I2C_BITS_PER_BYTE = 8;

    // quarters per SCL bit
    localparam int I2C_QUARTERS = 4;

endpackage

`default_nettype wire
